// ==== source/icache_ctrl_reg_pkg.sv ====
// Register map of the cache control unit; only the low OFFSET_W address bits are decoded
package icache_ctrl_reg_pkg;

   // Address bits that select a register
   localparam int unsigned OFFSET_W = 8;

   // Peripheral data width, also the width of the selective flush address
   localparam int unsigned DATA_W = 32;

   // Returned for offsets that have no readback, 0x08 included
   localparam logic [DATA_W-1:0] READ_INVALID = 32'hDEAD_CA5E;

   // Word offsets of the control registers
   typedef enum logic [OFFSET_W-1:0] {
      REG_ENABLE        = 8'h00, // Bit 0 enables all caches
      REG_FLUSH         = 8'h04, // Bit 0 flushes L1 and L2
      REG_FLUSH_L1_ONLY = 8'h08, // Bit 0 flushes the private L1 caches
      REG_SEL_FLUSH     = 8'h0C, // Address to flush selectively
      REG_PREFETCH      = 8'h1C  // L1 to L1.5 prefetch enable per core
   } ctrl_reg_e;

endpackage

// ==== source/icache_ctrl_sync_pkg.sv ====
// Opcodes and states shared by the controller FSM and the per-level trackers
package icache_ctrl_sync_pkg;

   // Maintenance operation sent to one cache level
   typedef enum logic [2:0] {
      OP_NONE,      // Nothing to wait for
      OP_ENABLE,    // Wait for bypass status low
      OP_DISABLE,   // Wait for bypass status high
      OP_FLUSH,
      OP_SEL_FLUSH
   } sync_op_e;

   // Controller state
   typedef enum logic {
      S_IDLE,  // Granting requests
      S_SYNC   // Waiting on the cache acks
   } ctrl_state_e;

endpackage

// ==== source/icache_ctrl_regs.sv ====
// Control registers; NB_CORES + NB_CACHE_BANKS must not exceed the 32-bit data width
`timescale 1ns/10ps

module icache_ctrl_regs #(
   parameter int unsigned NB_CORES       = 9,
   parameter int unsigned NB_CACHE_BANKS = 4,
   parameter int unsigned ID_WIDTH       = 5
) (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   input  logic                                   accept_i,
   input  logic                                   wr_en_i,
   input  logic                                   resp_i,
   input  logic                                   flush_clr_i,
   input  logic [icache_ctrl_reg_pkg::DATA_W-1:0] addr_i,
   input  logic [icache_ctrl_reg_pkg::DATA_W-1:0] wdata_i,
   input  logic [ID_WIDTH-1:0]                    id_i,
   output logic                                   r_valid_o,
   output logic [icache_ctrl_reg_pkg::DATA_W-1:0] r_rdata_o,
   output logic [ID_WIDTH-1:0]                    r_id_o,
   output logic [NB_CORES-1:0]                    l1_bypass_req_o,
   output logic [NB_CACHE_BANKS-1:0]              l2_bypass_req_o,
   output logic [icache_ctrl_reg_pkg::DATA_W-1:0] sel_flush_addr_o,
   output logic [NB_CORES-1:0]                    prefetch_en_o
);

   localparam int unsigned NB_TOT = NB_CORES + NB_CACHE_BANKS;

   logic                                   enable_q, enable_d;
   logic [NB_TOT-1:0]                      flush_q, flush_wr_d;
   logic [icache_ctrl_reg_pkg::DATA_W-1:0] sel_addr_q, sel_addr_d;
   logic [NB_CORES-1:0]                    prefetch_q, prefetch_d;
   logic [icache_ctrl_reg_pkg::DATA_W-1:0] addr_q;
   logic [ID_WIDTH-1:0]                    id_q;
   logic [icache_ctrl_reg_pkg::DATA_W-1:0] rd_addr;
   logic [icache_ctrl_reg_pkg::DATA_W-1:0] rdata_d;

   // Register values with the current write applied
   always_comb begin
      enable_d   = enable_q;
      flush_wr_d = flush_q;
      sel_addr_d = sel_addr_q;
      prefetch_d = prefetch_q;
      if (wr_en_i) begin
         case (addr_i[icache_ctrl_reg_pkg::OFFSET_W-1:0])
            icache_ctrl_reg_pkg::REG_ENABLE:        enable_d = wdata_i[0];
            icache_ctrl_reg_pkg::REG_FLUSH:         flush_wr_d = {NB_TOT{wdata_i[0]}};
            icache_ctrl_reg_pkg::REG_FLUSH_L1_ONLY: begin
               flush_wr_d = {{NB_CACHE_BANKS{1'b0}}, {NB_CORES{wdata_i[0]}}};
            end
            icache_ctrl_reg_pkg::REG_SEL_FLUSH:     sel_addr_d = wdata_i;
            icache_ctrl_reg_pkg::REG_PREFETCH:      prefetch_d = wdata_i[NB_CORES-1:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         enable_q   <= 1'b0;
         flush_q    <= '0;
         sel_addr_q <= '0;
         prefetch_q <= '0;
         r_valid_o  <= 1'b0;
      end else begin
         enable_q   <= enable_d;
         flush_q    <= flush_clr_i ? '0 : flush_wr_d; // Cleared once the flush is answered
         sel_addr_q <= sel_addr_d;
         prefetch_q <= prefetch_d;
         r_valid_o  <= resp_i;
      end
   end

   // Request context kept for the delayed answer of a sync write
   always_ff @(posedge clk_i) begin
      if (accept_i) begin
         addr_q <= addr_i;
         id_q   <= id_i;
      end
   end

   assign rd_addr = accept_i ? addr_i : addr_q;

   // Readback mux
   always_comb begin
      rdata_d = '0;
      case (rd_addr[icache_ctrl_reg_pkg::OFFSET_W-1:0])
         icache_ctrl_reg_pkg::REG_ENABLE:    rdata_d[NB_TOT-1:0] = {NB_TOT{enable_d}};
         icache_ctrl_reg_pkg::REG_FLUSH:     rdata_d[NB_TOT-1:0] = flush_wr_d; // L1 in low bits
         icache_ctrl_reg_pkg::REG_SEL_FLUSH: rdata_d = sel_addr_d;
         icache_ctrl_reg_pkg::REG_PREFETCH:  rdata_d[NB_CORES-1:0] = prefetch_d;
         default:                            rdata_d = icache_ctrl_reg_pkg::READ_INVALID;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (resp_i) begin
         r_rdata_o <= rdata_d;
         r_id_o    <= accept_i ? id_i : id_q;
      end
   end

   // Bypass requested on every port while disabled
   assign l1_bypass_req_o  = {NB_CORES{~enable_q}};
   assign l2_bypass_req_o  = {NB_CACHE_BANKS{~enable_q}};
   assign sel_flush_addr_o = sel_addr_q;
   assign prefetch_en_o    = prefetch_q;

endmodule

// ==== source/icache_level_sync.sv ====
// Tracks one cache level; acks may be pulses or levels, each is needed only once per port
`timescale 1ns/10ps

module icache_level_sync #(
   parameter int unsigned NB_PORTS = 4
) (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           start_i,
   input  icache_ctrl_sync_pkg::sync_op_e op_i,
   input  logic [NB_PORTS-1:0]            bypass_ack_i,
   input  logic [NB_PORTS-1:0]            flush_ack_i,
   input  logic [NB_PORTS-1:0]            sel_flush_ack_i,
   output logic [NB_PORTS-1:0]            flush_req_o,
   output logic [NB_PORTS-1:0]            sel_flush_req_o,
   output logic                           done_o
);

   icache_ctrl_sync_pkg::sync_op_e op_q;
   logic [NB_PORTS-1:0]            pending_q;
   logic [NB_PORTS-1:0]            port_done;

   // Per-port completion condition of the stored operation
   always_comb begin
      case (op_q)
         icache_ctrl_sync_pkg::OP_ENABLE:    port_done = ~bypass_ack_i;
         icache_ctrl_sync_pkg::OP_DISABLE:   port_done = bypass_ack_i;
         icache_ctrl_sync_pkg::OP_FLUSH:     port_done = flush_ack_i;
         icache_ctrl_sync_pkg::OP_SEL_FLUSH: port_done = sel_flush_ack_i;
         default:                            port_done = '0;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         op_q      <= icache_ctrl_sync_pkg::OP_NONE;
         pending_q <= '0;
      end else if (start_i) begin
         op_q      <= op_i;
         pending_q <= (op_i == icache_ctrl_sync_pkg::OP_NONE) ? '0 : '1;
      end else begin
         pending_q <= pending_q & ~port_done; // Sticky once a port is seen done
      end
   end

   // Requests stay up only on ports still pending
   assign flush_req_o     = (op_q == icache_ctrl_sync_pkg::OP_FLUSH) ? pending_q : '0;
   assign sel_flush_req_o = (op_q == icache_ctrl_sync_pkg::OP_SEL_FLUSH) ? pending_q : '0;

   assign done_o = (pending_q == '0);

endmodule

// ==== source/icache_ctrl_fsm.sv ====
// Controller FSM; one request at a time, grant is withheld while a maintenance op runs
`timescale 1ns/10ps

module icache_ctrl_fsm (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   input  logic                                   req_i,
   input  logic                                   wen_i,
   input  logic [icache_ctrl_reg_pkg::DATA_W-1:0] addr_i,
   input  logic                                   wdata0_i,
   output logic                                   gnt_o,
   output logic                                   accept_o,
   output logic                                   wr_en_o,
   output logic                                   resp_o,
   output logic                                   flush_clr_o,
   output logic                                   start_o,
   output icache_ctrl_sync_pkg::sync_op_e         l1_op_o,
   output icache_ctrl_sync_pkg::sync_op_e         l2_op_o,
   input  logic                                   l1_done_i,
   input  logic                                   l2_done_i
);

   icache_ctrl_sync_pkg::ctrl_state_e state_q, state_d;
   logic                              is_sync;
   logic                              flush_q;

   // Per-level opcode of a write
   always_comb begin
      is_sync = 1'b0;
      l1_op_o = icache_ctrl_sync_pkg::OP_NONE;
      l2_op_o = icache_ctrl_sync_pkg::OP_NONE;
      case (addr_i[icache_ctrl_reg_pkg::OFFSET_W-1:0])
         icache_ctrl_reg_pkg::REG_ENABLE: begin
            is_sync = 1'b1;
            l1_op_o = wdata0_i ? icache_ctrl_sync_pkg::OP_ENABLE
                               : icache_ctrl_sync_pkg::OP_DISABLE;
            l2_op_o = l1_op_o;
         end
         icache_ctrl_reg_pkg::REG_FLUSH: begin
            is_sync = 1'b1;
            if (wdata0_i) begin
               l1_op_o = icache_ctrl_sync_pkg::OP_FLUSH;
               l2_op_o = icache_ctrl_sync_pkg::OP_FLUSH;
            end
         end
         icache_ctrl_reg_pkg::REG_FLUSH_L1_ONLY: begin
            is_sync = 1'b1;
            if (wdata0_i) begin
               l1_op_o = icache_ctrl_sync_pkg::OP_FLUSH; // L2 left alone
            end
         end
         icache_ctrl_reg_pkg::REG_SEL_FLUSH: begin
            is_sync = 1'b1;
            l1_op_o = icache_ctrl_sync_pkg::OP_SEL_FLUSH;
            l2_op_o = icache_ctrl_sync_pkg::OP_SEL_FLUSH;
         end
         default: ;
      endcase
   end

   assign gnt_o    = (state_q == icache_ctrl_sync_pkg::S_IDLE);
   assign accept_o = req_i & gnt_o;
   assign wr_en_o  = accept_o & ~wen_i;

   always_comb begin
      state_d     = state_q;
      resp_o      = 1'b0;
      start_o     = 1'b0;
      flush_clr_o = 1'b0;
      case (state_q)
         icache_ctrl_sync_pkg::S_IDLE: begin
            if (accept_o) begin
               if (!wen_i && is_sync) begin
                  start_o = 1'b1;
                  state_d = icache_ctrl_sync_pkg::S_SYNC;
               end else begin
                  resp_o = 1'b1; // Reads and simple writes answer at once
               end
            end
         end
         icache_ctrl_sync_pkg::S_SYNC: begin
            if (l1_done_i && l2_done_i) begin
               resp_o      = 1'b1;
               flush_clr_o = flush_q;
               state_d     = icache_ctrl_sync_pkg::S_IDLE;
            end
         end
         default: state_d = icache_ctrl_sync_pkg::S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= icache_ctrl_sync_pkg::S_IDLE;
         flush_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (start_o) begin
            // Flush bits are cleared only after a real flush
            flush_q <= (l1_op_o == icache_ctrl_sync_pkg::OP_FLUSH);
         end
      end
   end

endmodule

// ==== source/icache_ctrl_unit.sv ====
// Cache control unit top; NB_CORES + NB_CACHE_BANKS must not exceed 32
`timescale 1ns/10ps

module icache_ctrl_unit #(
   parameter int unsigned NB_CORES       = 9,
   parameter int unsigned NB_CACHE_BANKS = 4,
   parameter int unsigned ID_WIDTH       = 5
) (
   input  logic                                   clk_i,
   input  logic                                   rst_ni,
   // Peripheral slave port
   input  logic                                   periph_req_i,
   input  logic [icache_ctrl_reg_pkg::DATA_W-1:0] periph_addr_i,
   input  logic                                   periph_wen_i,
   input  logic [icache_ctrl_reg_pkg::DATA_W-1:0] periph_wdata_i,
   input  logic [ID_WIDTH-1:0]                    periph_id_i,
   output logic                                   periph_gnt_o,
   output logic                                   periph_r_valid_o,
   output logic [ID_WIDTH-1:0]                    periph_r_id_o,
   output logic [icache_ctrl_reg_pkg::DATA_W-1:0] periph_r_rdata_o,
   // Private L1 caches
   output logic [NB_CORES-1:0]                    l1_bypass_req_o,
   input  logic [NB_CORES-1:0]                    l1_bypass_ack_i,
   output logic [NB_CORES-1:0]                    l1_flush_req_o,
   input  logic [NB_CORES-1:0]                    l1_flush_ack_i,
   output logic [NB_CORES-1:0]                    l1_sel_flush_req_o,
   input  logic [NB_CORES-1:0]                    l1_sel_flush_ack_i,
   // Shared L2 banks
   output logic [NB_CACHE_BANKS-1:0]              l2_bypass_req_o,
   input  logic [NB_CACHE_BANKS-1:0]              l2_bypass_ack_i,
   output logic [NB_CACHE_BANKS-1:0]              l2_flush_req_o,
   input  logic [NB_CACHE_BANKS-1:0]              l2_flush_ack_i,
   output logic [NB_CACHE_BANKS-1:0]              l2_sel_flush_req_o,
   input  logic [NB_CACHE_BANKS-1:0]              l2_sel_flush_ack_i,
   output logic [icache_ctrl_reg_pkg::DATA_W-1:0] sel_flush_addr_o,
   output logic [NB_CORES-1:0]                    l1_l15_prefetch_en_o
);

   logic                           accept, wr_en, resp, flush_clr, start;
   logic                           l1_done, l2_done;
   icache_ctrl_sync_pkg::sync_op_e l1_op, l2_op;

   icache_ctrl_regs #(
      .NB_CORES       (NB_CORES),
      .NB_CACHE_BANKS (NB_CACHE_BANKS),
      .ID_WIDTH       (ID_WIDTH)
   ) i_regs (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .accept_i         (accept),
      .wr_en_i          (wr_en),
      .resp_i           (resp),
      .flush_clr_i      (flush_clr),
      .addr_i           (periph_addr_i),
      .wdata_i          (periph_wdata_i),
      .id_i             (periph_id_i),
      .r_valid_o        (periph_r_valid_o),
      .r_rdata_o        (periph_r_rdata_o),
      .r_id_o           (periph_r_id_o),
      .l1_bypass_req_o  (l1_bypass_req_o),
      .l2_bypass_req_o  (l2_bypass_req_o),
      .sel_flush_addr_o (sel_flush_addr_o),
      .prefetch_en_o    (l1_l15_prefetch_en_o)
   );

   icache_ctrl_fsm i_fsm (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (periph_req_i),
      .wen_i       (periph_wen_i),
      .addr_i      (periph_addr_i),
      .wdata0_i    (periph_wdata_i[0]),
      .gnt_o       (periph_gnt_o),
      .accept_o    (accept),
      .wr_en_o     (wr_en),
      .resp_o      (resp),
      .flush_clr_o (flush_clr),
      .start_o     (start),
      .l1_op_o     (l1_op),
      .l2_op_o     (l2_op),
      .l1_done_i   (l1_done),
      .l2_done_i   (l2_done)
   );

   // One tracker per cache level
   icache_level_sync #(
      .NB_PORTS (NB_CORES)
   ) i_l1_sync (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .start_i         (start),
      .op_i            (l1_op),
      .bypass_ack_i    (l1_bypass_ack_i),
      .flush_ack_i     (l1_flush_ack_i),
      .sel_flush_ack_i (l1_sel_flush_ack_i),
      .flush_req_o     (l1_flush_req_o),
      .sel_flush_req_o (l1_sel_flush_req_o),
      .done_o          (l1_done)
   );

   icache_level_sync #(
      .NB_PORTS (NB_CACHE_BANKS)
   ) i_l2_sync (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .start_i         (start),
      .op_i            (l2_op),
      .bypass_ack_i    (l2_bypass_ack_i),
      .flush_ack_i     (l2_flush_ack_i),
      .sel_flush_ack_i (l2_sel_flush_ack_i),
      .flush_req_o     (l2_flush_req_o),
      .sel_flush_req_o (l2_sel_flush_req_o),
      .done_o          (l2_done)
   );

endmodule

// ==== test/cache_port_model.sv ====
// Behavioral cache level; each port answers after 0 to 7 random cycles, flush acks are pulses
`timescale 1ns/10ps

module cache_port_model #(
   parameter int unsigned NB_PORTS = 4,
   parameter int unsigned SEED_OFS = 0
) (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  logic [NB_PORTS-1:0] bypass_req_i,
   input  logic [NB_PORTS-1:0] flush_req_i,
   input  logic [NB_PORTS-1:0] sel_flush_req_i,
   output logic [NB_PORTS-1:0] bypass_ack_o,
   output logic [NB_PORTS-1:0] flush_ack_o,
   output logic [NB_PORTS-1:0] sel_flush_ack_o
);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   for (genvar p = 0; p < NB_PORTS; p++) begin : g_port
      logic [31:0] rng_q;
      logic [2:0]  cnt_q;
      logic        byp_q, fl_q, sel_q;
      logic        busy;

      // Something outstanding that this port has not answered yet
      assign busy = (byp_q != bypass_req_i[p]) || (flush_req_i[p] && !fl_q)
                    || (sel_flush_req_i[p] && !sel_q);

      always @(posedge clk_i or negedge rst_ni) begin
         if (!rst_ni) begin
            rng_q <= 32'd66 ^ ((SEED_OFS + p + 1) * 32'h9E37_79B9);
            cnt_q <= 3'd0;
            byp_q <= 1'b1; // Caches start in bypass
            fl_q  <= 1'b0;
            sel_q <= 1'b0;
         end else begin
            fl_q  <= 1'b0;
            sel_q <= 1'b0;
            if (!busy) begin
               rng_q <= xorshift32(rng_q); // Delay for the next request
               cnt_q <= rng_q[2:0];
            end else if (cnt_q != 3'd0) begin
               cnt_q <= cnt_q - 3'd1;
            end else begin
               byp_q <= bypass_req_i[p];
               fl_q  <= flush_req_i[p];
               sel_q <= sel_flush_req_i[p];
            end
         end
      end

      assign bypass_ack_o[p]    = byp_q;
      assign flush_ack_o[p]     = fl_q;
      assign sel_flush_ack_o[p] = sel_q;
   end

endmodule

// ==== test/tb_icache_ctrl_unit.sv ====
// Testbench for the cache control unit with default parameters (9 cores, 4 banks, 5-bit id)
`timescale 1ns/10ps

module tb_icache_ctrl_unit;

   localparam int unsigned WAIT_MAX = 200; // Cycles before a wait gives up

   logic        clk, rst_n;
   logic        req, wen, gnt, r_valid;
   logic [31:0] addr, wdata, r_rdata, sel_addr;
   logic [4:0]  id, r_id;
   logic [8:0]  l1_byp_req, l1_byp_ack, l1_fl_req, l1_fl_ack, l1_sel_req, l1_sel_ack, pref_en;
   logic [3:0]  l2_byp_req, l2_byp_ack, l2_fl_req, l2_fl_ack, l2_sel_req, l2_sel_ack;
   logic [31:0] exp_rdata, exp_sel_addr, rng;
   logic [4:0]  exp_id;
   logic [25:0] exp_req; // L1 flush, L2 flush, L1 selective, L2 selective
   logic        chk_bypass, bypass_exp, l2_quiet, chk_prefetch;
   logic        accepted, fast_req, sync_req;
   logic        timed_out;
   int unsigned errors, tests;

   icache_ctrl_unit i_dut (
      .clk_i (clk), .rst_ni (rst_n),
      .periph_req_i (req), .periph_addr_i (addr), .periph_wen_i (wen),
      .periph_wdata_i (wdata), .periph_id_i (id), .periph_gnt_o (gnt),
      .periph_r_valid_o (r_valid), .periph_r_id_o (r_id), .periph_r_rdata_o (r_rdata),
      .l1_bypass_req_o (l1_byp_req), .l1_bypass_ack_i (l1_byp_ack),
      .l1_flush_req_o (l1_fl_req), .l1_flush_ack_i (l1_fl_ack),
      .l1_sel_flush_req_o (l1_sel_req), .l1_sel_flush_ack_i (l1_sel_ack),
      .l2_bypass_req_o (l2_byp_req), .l2_bypass_ack_i (l2_byp_ack),
      .l2_flush_req_o (l2_fl_req), .l2_flush_ack_i (l2_fl_ack),
      .l2_sel_flush_req_o (l2_sel_req), .l2_sel_flush_ack_i (l2_sel_ack),
      .sel_flush_addr_o (sel_addr), .l1_l15_prefetch_en_o (pref_en)
   );

   cache_port_model #(.NB_PORTS (9), .SEED_OFS (0)) i_l1_model (
      .clk_i (clk), .rst_ni (rst_n), .bypass_req_i (l1_byp_req), .flush_req_i (l1_fl_req),
      .sel_flush_req_i (l1_sel_req), .bypass_ack_o (l1_byp_ack), .flush_ack_o (l1_fl_ack),
      .sel_flush_ack_o (l1_sel_ack)
   );

   cache_port_model #(.NB_PORTS (4), .SEED_OFS (16)) i_l2_model (
      .clk_i (clk), .rst_ni (rst_n), .bypass_req_i (l2_byp_req), .flush_req_i (l2_fl_req),
      .sel_flush_req_i (l2_sel_req), .bypass_ack_o (l2_byp_ack), .flush_ack_o (l2_fl_ack),
      .sel_flush_ack_o (l2_sel_ack)
   );

   always #5 clk = ~clk;

   // Offsets 0x00 to 0x0C wait for the caches, everything else answers at once
   assign accepted = req & gnt;
   assign sync_req = accepted & ~wen & (addr[7:0] inside {8'h00, 8'h04, 8'h08, 8'h0C});
   assign fast_req = accepted & ~sync_req;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   assert property (@(posedge clk) disable iff (!rst_n) r_valid |-> r_rdata == exp_rdata)
      else begin
         errors++;
         $display("Mismatch periph_r_rdata_o: got %h, expected %h",
                  $sampled(r_rdata), exp_rdata);
      end
   assert property (@(posedge clk) disable iff (!rst_n) r_valid |-> r_id == exp_id)
      else begin
         errors++;
         $display("Mismatch periph_r_id_o: got %h, expected %h", $sampled(r_id), exp_id);
      end
   assert property (@(posedge clk) disable iff (!rst_n) fast_req |=> r_valid)
      else begin
         errors++;
         $display("Response did not come one cycle after a read or simple write");
      end
   assert property (@(posedge clk) disable iff (!rst_n) sync_req |=> !gnt && !r_valid)
      else begin
         errors++;
         $display("Maintenance write answered or granted again too early");
      end
   // Every port of the operation is requested right after acceptance
   assert property (@(posedge clk) disable iff (!rst_n)
                    sync_req |=> {l1_fl_req, l2_fl_req, l1_sel_req, l2_sel_req} == exp_req)
      else begin
         errors++;
         $display("Mismatch flush_req and sel_flush_req: got %h, expected %h",
                  $sampled({l1_fl_req, l2_fl_req, l1_sel_req, l2_sel_req}), exp_req);
      end
   assert property (@(posedge clk) disable iff (!rst_n) $rose(gnt) |-> r_valid)
      else begin
         errors++;
         $display("Grant came back without the response");
      end
   assert property (@(posedge clk) disable iff (!rst_n)
                    r_valid && chk_bypass |-> {l1_byp_ack, l2_byp_ack} == {13{bypass_exp}})
      else begin
         errors++;
         $display("Mismatch bypass_ack: got %h, expected %h",
                  $sampled({l1_byp_ack, l2_byp_ack}), {13{bypass_exp}});
      end
   assert property (@(posedge clk) disable iff (!rst_n) l2_quiet |-> l2_fl_req == 4'h0)
      else begin
         errors++;
         $display("Mismatch l2_flush_req_o: got %h, expected 0", $sampled(l2_fl_req));
      end
   // A request bit may only rise right after an accepted request
   assert property (@(posedge clk) disable iff (!rst_n) !$past(accepted) |->
                    ({l1_fl_req, l2_fl_req, l1_sel_req, l2_sel_req}
                     & ~$past({l1_fl_req, l2_fl_req, l1_sel_req, l2_sel_req})) == 26'h0)
      else begin
         errors++;
         $display("A flush request rose again after its ack");
      end
   assert property (@(posedge clk) disable iff (!rst_n)
                    |{l1_sel_req, l2_sel_req} |-> sel_addr == exp_sel_addr)
      else begin
         errors++;
         $display("Mismatch sel_flush_addr_o: got %h, expected %h",
                  $sampled(sel_addr), exp_sel_addr);
      end
   assert property (@(posedge clk) disable iff (!rst_n)
                    r_valid && chk_prefetch |-> pref_en == exp_rdata[8:0])
      else begin
         errors++;
         $display("Mismatch l1_l15_prefetch_en_o: got %h, expected %h",
                  $sampled(pref_en), exp_rdata[8:0]);
      end

   task automatic report_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      errors++;
      timed_out = 1'b1;
   endtask

   // One peripheral access, returns after the response cycle has been sampled
   task automatic access(input logic write, input logic [7:0] off, input logic [31:0] data,
                         input logic [31:0] expect_data);
      int unsigned n;
      if (!timed_out) begin
         rng       = xorshift32(rng);
         exp_rdata = expect_data;
         exp_id    = rng[4:0];
         req   = 1'b1;
         wen   = ~write;
         addr  = {24'h0, off};
         wdata = data;
         id    = rng[4:0];
         n = 0;
         while (!gnt && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
         end
         if (!gnt) begin
            req = 1'b0;
            report_timeout("the grant");
         end else begin
            @(posedge clk);
            #1;
            req = 1'b0;
            n = 0;
            while (!r_valid && n < WAIT_MAX) begin
               @(posedge clk);
               #1;
               n++;
            end
            if (!r_valid) begin
               report_timeout("the response");
            end else begin
               @(posedge clk); // Let the checks sample the response
               #1;
            end
         end
      end
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("Test %0d (%s) finished, errors so far %0d", tests, name, errors);
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      req = 1'b0;
      wen = 1'b1;
      addr = '0;
      wdata = '0;
      id = '0;
      exp_rdata = '0;
      exp_id = '0;
      exp_sel_addr = '0;
      exp_req = '0;
      rng = 32'd66;
      chk_bypass = 1'b0;
      bypass_exp = 1'b1;
      l2_quiet = 1'b0;
      chk_prefetch = 1'b0;
      timed_out = 1'b0;
      errors = 0;
      tests = 0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;

      assert ({l1_byp_req, l2_byp_req} == 13'h1FFF)
         else begin
            errors++;
            $display("Mismatch bypass_req: got %h, expected 1fff", {l1_byp_req, l2_byp_req});
         end
      assert ({l1_fl_req, l2_fl_req, l1_sel_req, l2_sel_req} == 26'h0)
         else begin
            errors++;
            $display("Mismatch flush_req and sel_flush_req: got %h, expected 0",
                     {l1_fl_req, l2_fl_req, l1_sel_req, l2_sel_req});
         end
      assert ({gnt, r_valid} == 2'b10)
         else begin
            errors++;
            $display("Mismatch periph_gnt_o and periph_r_valid_o: got %h, expected 2",
                     {gnt, r_valid});
         end
      access(1'b0, 8'h00, 32'h0, 32'h0);
      access(1'b0, 8'h1C, 32'h0, 32'h0);
      access(1'b0, 8'h20, 32'h0, 32'hDEAD_CA5E);
      end_test("reset and reads");

      chk_bypass = 1'b1;
      bypass_exp = 1'b0;
      access(1'b1, 8'h00, 32'h1, 32'h0000_1FFF);
      bypass_exp = 1'b1;
      access(1'b1, 8'h00, 32'h0, 32'h0);
      chk_bypass = 1'b0;
      end_test("enable and disable");

      exp_req = {9'h1FF, 4'hF, 9'h000, 4'h0};
      access(1'b1, 8'h04, 32'h1, 32'h0000_1FFF);
      access(1'b0, 8'h04, 32'h0, 32'h0);
      end_test("flush all");

      // No readback at this offset, the L1 ones show on the requests
      l2_quiet = 1'b1;
      exp_req = {9'h1FF, 4'h0, 9'h000, 4'h0};
      access(1'b1, 8'h08, 32'h1, 32'hDEAD_CA5E);
      l2_quiet = 1'b0;
      end_test("flush L1 only");

      rng = xorshift32(rng);
      exp_sel_addr = rng;
      exp_req = {9'h000, 4'h0, 9'h1FF, 4'hF};
      access(1'b1, 8'h0C, exp_sel_addr, exp_sel_addr);
      end_test("selective flush");

      rng = xorshift32(rng);
      chk_prefetch = 1'b1;
      access(1'b1, 8'h1C, rng, rng & 32'h0000_01FF);
      chk_prefetch = 1'b0;
      end_test("prefetch enables");

      $display("Tests run %0d, errors %0d", tests, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
source/icache_ctrl_reg_pkg.sv
source/icache_ctrl_sync_pkg.sv
source/icache_ctrl_regs.sv
source/icache_level_sync.sv
source/icache_ctrl_fsm.sv
source/icache_ctrl_unit.sv
test/cache_port_model.sv
test/tb_icache_ctrl_unit.sv
